/* hl_pkg.sv */
package hl_pkg;

	// Converter sample, two's complement
	localparam int ADC_W = 12;

	// Decimated word, holds the sign-extended sum of DECIM samples
	localparam int WORD_W = 16;

	// Samples added into one word
	localparam int DECIM = 4;
	localparam int DECIM_CNT_W = $clog2(DECIM);

	// Sample buffer size, also the starting credit count
	localparam int FIFO_DEPTH = 16;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Fill level and credit count, must reach FIFO_DEPTH
	localparam int LEVEL_W = 5;

	// Frame layout
	localparam int FRAME_WORDS = 8;
	localparam int WORD_CNT_W = $clog2(FRAME_WORDS);
	localparam logic [7:0] FRAME_MARK = 8'ha5;
	localparam int HDR_NIBBLES = 4;
	localparam int WORD_NIBBLES = 4;
	localparam int NIB_W = $clog2((HDR_NIBBLES > WORD_NIBBLES) ? HDR_NIBBLES : WORD_NIBBLES);

	// Minimum idle cycles between frames
	localparam int IFG_NIBBLES = 4;
	localparam int GAP_W = $clog2(IFG_NIBBLES + 1);

endpackage

/* rx_decimator.sv */
`timescale 1ns/1ps

module rx_decimator (
	input  logic                          if_clk_i,
	input  logic                          rst_n_i,
	input  logic [hl_pkg::ADC_W-1:0]      adc_data_i,
	input  logic                          adc_valid_i,
	input  logic                          credit_i,
	output logic                          push_o,
	output logic [hl_pkg::WORD_W-1:0]     push_data_o,
	output logic                          overrun_o
);

	logic [hl_pkg::WORD_W-1:0]      sample_ext;
	logic [hl_pkg::WORD_W-1:0]      acc;
	logic [hl_pkg::WORD_W-1:0]      acc_next;
	logic [hl_pkg::DECIM_CNT_W-1:0] grp_cnt;
	logic [hl_pkg::LEVEL_W-1:0]     credit_cnt;
	logic                           group_end;
	logic                           has_credit;
	logic                           take;

	// Sign extend the converter sample to word width
	assign sample_ext = {{(hl_pkg::WORD_W - hl_pkg::ADC_W){adc_data_i[hl_pkg::ADC_W-1]}},
		adc_data_i};
	assign acc_next = acc + sample_ext;

	// Last sample of a group accepted this cycle
	assign group_end = adc_valid_i &&
		(grp_cnt == hl_pkg::DECIM_CNT_W'(hl_pkg::DECIM - 1));
	assign has_credit = (credit_cnt != '0);
	// Word goes to the buffer only with a free slot
	assign take = group_end && has_credit;

	always_ff @(posedge if_clk_i) begin
		if (!rst_n_i) begin
			acc <= '0;
			grp_cnt <= '0;
			push_o <= 1'b0;
			overrun_o <= 1'b0;
			credit_cnt <= hl_pkg::LEVEL_W'(hl_pkg::FIFO_DEPTH);
		end else begin
			push_o <= take;
			if (adc_valid_i) begin
				if (group_end) begin
					// Start a fresh group
					acc <= '0;
					grp_cnt <= '0;
				end else begin
					acc <= acc_next;
					grp_cnt <= grp_cnt + 1'b1;
				end
			end
			// Dropped word, flag stays until reset
			if (group_end && !has_credit) begin
				overrun_o <= 1'b1;
			end
			// Push spends one credit, a return gives one back
			case ({take, credit_i})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Completed sum, held until the next group ends
	always_ff @(posedge if_clk_i) begin
		if (group_end) begin
			push_data_o <= acc_next;
		end
	end

endmodule

/* sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo (
	input  logic                          if_clk_i,
	input  logic                          rst_n_i,
	input  logic                          push_i,
	input  logic [hl_pkg::WORD_W-1:0]     push_data_i,
	input  logic                          pop_i,
	output logic [hl_pkg::WORD_W-1:0]     rd_data_o,
	output logic [hl_pkg::LEVEL_W-1:0]    level_o,
	output logic                          credit_o
);

	logic [hl_pkg::WORD_W-1:0] mem [hl_pkg::FIFO_DEPTH];
	logic [hl_pkg::PTR_W-1:0]  wr_ptr;
	logic [hl_pkg::PTR_W-1:0]  rd_ptr;

	// Oldest word is valid while level is nonzero
	assign rd_data_o = mem[rd_ptr];

	always_ff @(posedge if_clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level_o <= '0;
			credit_o <= 1'b0;
		end else begin
			// Pointers wrap at the power-of-two depth
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10: level_o <= level_o + 1'b1;
				2'b01: level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
			// One credit back per word taken out
			credit_o <= pop_i;
		end
	end

	// Storage array
	always_ff @(posedge if_clk_i) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

endmodule

/* mii_framer.sv */
`timescale 1ns/1ps

module mii_framer (
	input  logic                          if_clk_i,
	input  logic                          rst_n_i,
	input  logic [hl_pkg::LEVEL_W-1:0]    level_i,
	input  logic [hl_pkg::WORD_W-1:0]     rd_data_i,
	output logic                          pop_o,
	output logic [3:0]                    phy_txd_o,
	output logic                          phy_tx_en_o
);

	typedef enum logic [1:0] {
		S_GAP,
		S_HEADER,
		S_PAYLOAD
	} state_t;

	state_t                        state;
	logic [hl_pkg::NIB_W-1:0]      nib_cnt;
	logic [hl_pkg::WORD_CNT_W-1:0] word_cnt;
	logic [hl_pkg::GAP_W-1:0]      gap_cnt;
	logic [7:0]                    seq;
	logic [15:0]                   hdr;
	logic [hl_pkg::WORD_W-1:0]     word_q;
	logic                          frame_ready;

	// Mark byte first, then sequence, each low nibble first
	assign hdr = {seq, hl_pkg::FRAME_MARK};

	// Whole frame stored and gap served
	assign frame_ready = (level_i >= hl_pkg::LEVEL_W'(hl_pkg::FRAME_WORDS)) &&
		(gap_cnt >= hl_pkg::GAP_W'(hl_pkg::IFG_NIBBLES));

	always_ff @(posedge if_clk_i) begin
		if (!rst_n_i) begin
			state <= S_GAP;
			nib_cnt <= '0;
			word_cnt <= '0;
			gap_cnt <= hl_pkg::GAP_W'(hl_pkg::IFG_NIBBLES);
			seq <= '0;
			pop_o <= 1'b0;
			phy_txd_o <= '0;
			phy_tx_en_o <= 1'b0;
		end else begin
			pop_o <= 1'b0;
			case (state)
				S_GAP: begin
					if (frame_ready) begin
						// First header nibble goes out now
						phy_tx_en_o <= 1'b1;
						phy_txd_o <= hdr[3:0];
						nib_cnt <= hl_pkg::NIB_W'(1);
						state <= S_HEADER;
					end else begin
						phy_tx_en_o <= 1'b0;
						phy_txd_o <= '0;
						// Saturate once the gap is long enough
						if (gap_cnt < hl_pkg::GAP_W'(hl_pkg::IFG_NIBBLES)) begin
							gap_cnt <= gap_cnt + 1'b1;
						end
					end
				end
				S_HEADER: begin
					phy_txd_o <= hdr[nib_cnt*4 +: 4];
					if (nib_cnt == hl_pkg::NIB_W'(hl_pkg::HDR_NIBBLES - 1)) begin
						nib_cnt <= '0;
						word_cnt <= '0;
						state <= S_PAYLOAD;
					end else begin
						nib_cnt <= nib_cnt + 1'b1;
					end
				end
				S_PAYLOAD: begin
					if (nib_cnt == '0) begin
						// Pop while the word's first nibble is on the pins
						phy_txd_o <= rd_data_i[3:0];
						pop_o <= 1'b1;
					end else begin
						phy_txd_o <= word_q[nib_cnt*4 +: 4];
					end
					if (nib_cnt == hl_pkg::NIB_W'(hl_pkg::WORD_NIBBLES - 1)) begin
						nib_cnt <= '0;
						word_cnt <= word_cnt + 1'b1;
						// Last nibble of the frame
						if (word_cnt == hl_pkg::WORD_CNT_W'(hl_pkg::FRAME_WORDS - 1)) begin
							seq <= seq + 1'b1;
							gap_cnt <= '0;
							state <= S_GAP;
						end
					end else begin
						nib_cnt <= nib_cnt + 1'b1;
					end
				end
				default: begin
					state <= S_GAP;
				end
			endcase
		end
	end

	// Hold the word being sent, the buffer moves on after the pop
	always_ff @(posedge if_clk_i) begin
		if (state == S_PAYLOAD && nib_cnt == '0) begin
			word_q <= rd_data_i;
		end
	end

endmodule

/* hermes_lite_rx.sv */
`timescale 1ns/1ps

module hermes_lite_rx (
	input  logic                          if_clk_i,
	input  logic                          rst_n_i,
	input  logic [hl_pkg::ADC_W-1:0]      adc_data_i,
	input  logic                          adc_valid_i,
	output logic [3:0]                    phy_txd_o,
	output logic                          phy_tx_en_o,
	output logic                          overrun_o
);

	// Decimator to buffer
	logic                          push;
	logic [hl_pkg::WORD_W-1:0]     push_data;
	logic                          credit_return;

	// Buffer to framer
	logic [hl_pkg::LEVEL_W-1:0]    level;
	logic [hl_pkg::WORD_W-1:0]     rd_data;
	logic                          pop;

	// Sums groups of samples, spends credits
	rx_decimator rx_decimator_inst (
		.if_clk_i    (if_clk_i),
		.rst_n_i     (rst_n_i),
		.adc_data_i  (adc_data_i),
		.adc_valid_i (adc_valid_i),
		.credit_i    (credit_return),
		.push_o      (push),
		.push_data_o (push_data),
		.overrun_o   (overrun_o)
	);

	// Word store, credit back on each pop
	sample_fifo sample_fifo_inst (
		.if_clk_i    (if_clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (pop),
		.rd_data_o   (rd_data),
		.level_o     (level),
		.credit_o    (credit_return)
	);

	// Nibble frames onto the PHY transmit pins
	mii_framer mii_framer_inst (
		.if_clk_i    (if_clk_i),
		.rst_n_i     (rst_n_i),
		.level_i     (level),
		.rd_data_i   (rd_data),
		.pop_o       (pop),
		.phy_txd_o   (phy_txd_o),
		.phy_tx_en_o (phy_tx_en_o)
	);

endmodule

/* tb_hermes_lite_rx.sv */
`timescale 1ns/1ps

module tb_hermes_lite_rx;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic [hl_pkg::ADC_W-1:0]     adc_data;
	logic                         adc_valid;
	logic [3:0]                   phy_txd;
	logic                         phy_tx_en;
	logic                         overrun;

	// Reference model state
	logic [hl_pkg::WORD_W-1:0]    model_q [$];
	int                           model_acc = 0;
	int                           model_cnt = 0;

	// Monitor state
	logic [3:0]  frame_nib [hl_pkg::HDR_NIBBLES + hl_pkg::FRAME_WORDS * hl_pkg::WORD_NIBBLES];
	int          nib_cnt = 0;
	int          gap_len = 0;
	int          frames_seen = 0;
	int          since_reset = 0;
	int          phase = 0;
	logic [7:0]  exp_seq = 8'h00;
	bit          en_prev = 1'b0;
	bit          overrun_seen = 1'b0;

	hermes_lite_rx dut_i (
		.if_clk_i    (clk),
		.rst_n_i     (rst_n),
		.adc_data_i  (adc_data),
		.adc_valid_i (adc_valid),
		.phy_txd_o   (phy_txd),
		.phy_tx_en_o (phy_tx_en),
		.overrun_o   (overrun)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("tests failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_timeout(input string msg);
		$display("Timeout: %s", msg);
		$display("tests failed");
		$fatal(1, "stopped on timeout");
	endtask

	// Drive one input cycle that is valid with a chance of pct percent
	task automatic drive_sample(input int pct);
		logic                     v;
		logic [hl_pkg::ADC_W-1:0] d;
		v = (int'($urandom % 100) < pct);
		d = hl_pkg::ADC_W'($urandom);
		@(posedge clk);
		adc_valid <= v;
		adc_data <= d;
		// Every group of DECIM valid samples gives one expected word
		if (v) begin
			model_acc = model_acc + int'($signed(d));
			model_cnt = model_cnt + 1;
			if (model_cnt == hl_pkg::DECIM) begin
				model_q.push_back(hl_pkg::WORD_W'(model_acc));
				model_acc = 0;
				model_cnt = 0;
			end
		end
	endtask

	task automatic run_until_frames(input int target, input int pct);
		int cycles;
		int limit;
		cycles = 0;
		limit = (target - frames_seen) * 400;
		while (frames_seen < target && cycles < limit) begin
			drive_sample(pct);
			cycles = cycles + 1;
		end
		if (frames_seen < target) begin
			report_timeout($sformatf("no frame arrived within %0d cycles", limit));
		end
	endtask

	// Header, sequence and payload words of one captured frame
	task automatic check_frame();
		logic [7:0]                mark;
		logic [7:0]                seq_b;
		logic [hl_pkg::WORD_W-1:0] got;
		logic [hl_pkg::WORD_W-1:0] exp;
		bit                        found;
		int                        w;
		int                        base;
		mark = {frame_nib[1], frame_nib[0]};
		seq_b = {frame_nib[3], frame_nib[2]};
		assert (mark == hl_pkg::FRAME_MARK)
			else report_failure($sformatf("frame mark %h, expected %h",
				mark, hl_pkg::FRAME_MARK));
		assert (seq_b == exp_seq)
			else report_failure($sformatf("sequence %h, expected %h", seq_b, exp_seq));
		exp_seq = exp_seq + 8'd1;
		for (w = 0; w < hl_pkg::FRAME_WORDS; w++) begin
			base = hl_pkg::HDR_NIBBLES + w * hl_pkg::WORD_NIBBLES;
			got = {frame_nib[base+3], frame_nib[base+2], frame_nib[base+1], frame_nib[base]};
			if (phase == 1) begin
				// Strict order with no drops allowed
				assert (model_q.size() != 0)
					else report_failure("frame word sent with no model sum left");
				exp = model_q.pop_front();
				assert (got == exp)
					else report_failure($sformatf("word %0d got %h, expected %h",
						w, got, exp));
			end else begin
				// Dropped sums may be skipped but never reordered
				found = 1'b0;
				while (!found && model_q.size() != 0) begin
					exp = model_q.pop_front();
					found = (exp == got);
				end
				assert (found)
					else report_failure($sformatf("word %0d value %h matches no later sum",
						w, got));
			end
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			assert (!phy_tx_en && !overrun)
				else report_failure("output active during reset");
			since_reset = 0;
		end else begin
			if (since_reset < 4) begin
				assert (!phy_tx_en && !overrun)
					else report_failure("output active right after reset");
				since_reset = since_reset + 1;
			end
			if (phase == 1) begin
				assert (!overrun) else report_failure("overrun set at low input rate");
			end
			if (overrun_seen) begin
				assert (overrun) else report_failure("overrun flag dropped before reset");
			end
			if (overrun) begin
				overrun_seen = 1'b1;
			end
			if (phy_tx_en) begin
				if (!en_prev) begin
					if (frames_seen > 0) begin
						assert (gap_len >= hl_pkg::IFG_NIBBLES)
							else report_failure($sformatf("gap of %0d cycles", gap_len));
					end
					nib_cnt = 0;
				end
				assert (nib_cnt < $size(frame_nib))
					else report_failure("frame longer than expected");
				frame_nib[nib_cnt] = phy_txd;
				nib_cnt = nib_cnt + 1;
			end else begin
				// Falling tx enable ends a frame
				if (en_prev) begin
					assert (nib_cnt == $size(frame_nib))
						else report_failure($sformatf("frame of %0d nibbles", nib_cnt));
					check_frame();
					frames_seen = frames_seen + 1;
					gap_len = 0;
				end
				gap_len = gap_len + 1;
			end
			en_prev = phy_tx_en;
		end
	end

	initial begin
		rst_n = 1'b0;
		adc_valid = 1'b0;
		adc_data = '0;
		void'($urandom(32'hf5aa));
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		// Sparse input keeps credits available
		phase = 1;
		run_until_frames(6, 40);
		// Full rate input outruns the framer
		phase = 2;
		run_until_frames(18, 100);
		if (overrun_seen) begin
			$display("all tests passed");
			$finish;
		end else begin
			report_failure("overrun never set at full input rate");
		end
	end

endmodule

/* list.f */
hl_pkg.sv
rx_decimator.sv
sample_fifo.sv
mii_framer.sv
hermes_lite_rx.sv
tb_hermes_lite_rx.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_hermes_lite_rx
FILELIST = list.f
PASS_MSG = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
